//--- include/bridge_macros.svh
// ------------------------------
// Sizes shared by RTL and testbench
// FIFO depth must be a power of two
// Address splits into upper bits, slave index and offset
// ------------------------------
`ifndef BRIDGE_MACROS_SVH
`define BRIDGE_MACROS_SVH

// Bus widths
`define BRIDGE_ADDR_WIDTH 32
`define BRIDGE_DATA_WIDTH 32

// APB slave decode, index sits just above the offset
`define BRIDGE_NUM_SLAVES 4
`define BRIDGE_SLAVE_BITS 2
`define BRIDGE_OFFSET_BITS 12

// Entries per FIFO
`define BRIDGE_FIFO_DEPTH 4

`endif

//--- verilog/axi_pkg.sv
// ------------------------------
// AXI side types
// Only OKAY and SLVERR are ever returned
// ------------------------------
`default_nettype none

`include "bridge_macros.svh"

package axi_pkg;

  // Response codes on BRESP and RRESP
  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    SLVERR = 2'b10
  } axi_resp_e;

  // One read result, error bit in the LSB
  typedef struct packed {
    logic [`BRIDGE_DATA_WIDTH-1:0] data;
    logic                          error;
  } rd_rsp_t;

endpackage

`default_nettype wire

//--- verilog/apb_pkg.sv
// ------------------------------
// APB side types
// Commands carry no byte strobes
// Slave index comes from address bits 13:12
// ------------------------------
`default_nettype none

`include "bridge_macros.svh"

package apb_pkg;

  // One address word, seen flat or split into fields
  typedef union packed {
    logic [`BRIDGE_ADDR_WIDTH-1:0] flat;
    struct packed {
      logic [`BRIDGE_ADDR_WIDTH-`BRIDGE_SLAVE_BITS-`BRIDGE_OFFSET_BITS-1:0] upper;
      logic [`BRIDGE_SLAVE_BITS-1:0]  slave;
      logic [`BRIDGE_OFFSET_BITS-1:0] offset;
    } fields;
  } apb_addr_u;

  // Command FIFO entry, write flag on top
  typedef struct packed {
    logic                          write;
    apb_addr_u                     addr;
    logic [`BRIDGE_DATA_WIDTH-1:0] wdata;
  } apb_cmd_t;

  // Transfer phases
  typedef enum logic [1:0] {IDLE, SETUP, ACCESS} apb_state_e;

endpackage

`default_nettype wire

//--- verilog/sync_fifo.sv
// ------------------------------
// Single clock FIFO
// depth must be a power of two
// Push when full and pop when empty are dropped
// Output shows the head combinationally
// ------------------------------
`default_nettype none

module sync_fifo #(
  parameter int width = 8,
  parameter int depth = 4
) (
  input  logic             aclk,
  input  logic             reset,
  input  logic             push,
  input  logic [width-1:0] push_data,
  output logic             full,
  input  logic             pop,
  output logic [width-1:0] pop_data,
  output logic             empty
);

  localparam int ptr_bits = $clog2(depth);

  // Storage
  logic [width-1:0] mem [depth];

  // Pointers with one extra wrap bit
  logic [ptr_bits:0] wr_ptr;
  logic [ptr_bits:0] rd_ptr;

  // Same slot, different lap means full
  assign empty = (wr_ptr == rd_ptr);
  assign full  = (wr_ptr[ptr_bits] != rd_ptr[ptr_bits]) &&
                 (wr_ptr[ptr_bits-1:0] == rd_ptr[ptr_bits-1:0]);

  assign pop_data = mem[rd_ptr[ptr_bits-1:0]];

  always_ff @(posedge aclk) begin
    if (push && !full) begin
      mem[wr_ptr[ptr_bits-1:0]] <= push_data;
    end
  end

  // ------------------------------
  // Pointer update
  // ------------------------------
  always_ff @(posedge aclk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (push && !full) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop && !empty) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- verilog/axi_lite_front.sv
// ------------------------------
// AXI4-Lite slave front end
// AW and W are taken together in one cycle
// Write beats read when both are offered
// Readies stay low for the first cycle after reset
// ------------------------------
`default_nettype none

`include "bridge_macros.svh"

module axi_lite_front (
  input  logic                          aclk,
  input  logic                          reset,
  // Write address and data
  input  logic [`BRIDGE_ADDR_WIDTH-1:0] awaddr,
  input  logic                          awvalid,
  output logic                          awready,
  input  logic [`BRIDGE_DATA_WIDTH-1:0] wdata,
  input  logic                          wvalid,
  output logic                          wready,
  // Write response
  output axi_pkg::axi_resp_e            bresp,
  output logic                          bvalid,
  input  logic                          bready,
  // Read address and data
  input  logic [`BRIDGE_ADDR_WIDTH-1:0] araddr,
  input  logic                          arvalid,
  output logic                          arready,
  output logic [`BRIDGE_DATA_WIDTH-1:0] rdata,
  output axi_pkg::axi_resp_e            rresp,
  output logic                          rvalid,
  input  logic                          rready,
  // Command FIFO
  output logic                          cmd_push,
  output apb_pkg::apb_cmd_t             cmd_data,
  input  logic                          cmd_full,
  // Response FIFOs
  output logic                          wr_rsp_pop,
  input  logic                          wr_rsp_error,
  input  logic                          wr_rsp_empty,
  output logic                          rd_rsp_pop,
  input  axi_pkg::rd_rsp_t              rd_rsp_data,
  input  logic                          rd_rsp_empty
);

  logic live;
  logic room;
  logic wr_accept;
  logic rd_accept;

  // Set once reset has been released
  always_ff @(posedge aclk) begin
    if (reset) begin
      live <= 1'b0;
    end else begin
      live <= 1'b1;
    end
  end

  // ------------------------------
  // Arbitration
  // ------------------------------
  assign room      = live && !cmd_full;
  assign wr_accept = awvalid && wvalid && room;
  // Read waits whenever a full write is on offer
  assign rd_accept = arvalid && !wr_accept && room;

  // Each ready depends on its partner channel
  assign awready = wvalid && room;
  assign wready  = awvalid && room;
  assign arready = room && !(awvalid && wvalid);

  assign cmd_push = wr_accept || rd_accept;

  // Pack whichever side won
  always_comb begin
    cmd_data.write     = wr_accept;
    cmd_data.addr.flat = wr_accept ? awaddr : araddr;
    cmd_data.wdata     = wdata;
  end

  // ------------------------------
  // B and R channels
  // ------------------------------
  assign bvalid     = !wr_rsp_empty;
  assign bresp      = wr_rsp_error ? axi_pkg::SLVERR : axi_pkg::OKAY;
  assign wr_rsp_pop = bvalid && bready;

  assign rvalid     = !rd_rsp_empty;
  assign rdata      = rd_rsp_data.data;
  assign rresp      = rd_rsp_data.error ? axi_pkg::SLVERR : axi_pkg::OKAY;
  assign rd_rsp_pop = rvalid && rready;

endmodule

`default_nettype wire

//--- verilog/apb_master.sv
// ------------------------------
// APB master, one transfer at a time
// A command is taken only when its response FIFO has room
// PREADY and PSLVERR count only from the selected slave
// ------------------------------
`default_nettype none

`include "bridge_macros.svh"

module apb_master (
  input  logic                          aclk,
  input  logic                          reset,
  // Command FIFO head
  input  apb_pkg::apb_cmd_t             cmd_data,
  input  logic                          cmd_empty,
  output logic                          cmd_pop,
  // Response FIFOs
  input  logic                          wr_rsp_full,
  output logic                          wr_rsp_push,
  output logic                          wr_rsp_error,
  input  logic                          rd_rsp_full,
  output logic                          rd_rsp_push,
  output axi_pkg::rd_rsp_t              rd_rsp_data,
  // APB bus
  output logic [`BRIDGE_ADDR_WIDTH-1:0] paddr,
  output logic [`BRIDGE_DATA_WIDTH-1:0] pwdata,
  output logic [`BRIDGE_NUM_SLAVES-1:0] psel,
  output logic                          penable,
  output logic                          pwrite,
  input  logic [`BRIDGE_DATA_WIDTH-1:0] prdata,
  input  logic [`BRIDGE_NUM_SLAVES-1:0] pready,
  input  logic [`BRIDGE_NUM_SLAVES-1:0] pslverr
);

  localparam logic [`BRIDGE_NUM_SLAVES-1:0] sel_base = 1;

  apb_pkg::apb_state_e state;
  apb_pkg::apb_cmd_t   cmd_q;
  logic                rsp_room;
  logic                pready_sel;
  logic                pslverr_sel;
  logic                done;

  // Room in the FIFO this command will answer into
  assign rsp_room = cmd_data.write ? !wr_rsp_full : !rd_rsp_full;
  assign cmd_pop  = (state == apb_pkg::IDLE) && !cmd_empty && rsp_room;

  // ------------------------------
  // Transfer FSM
  // ------------------------------
  always_ff @(posedge aclk) begin
    if (reset) begin
      state <= apb_pkg::IDLE;
    end else begin
      case (state)
        apb_pkg::IDLE:   if (cmd_pop) state <= apb_pkg::SETUP;
        apb_pkg::SETUP:  state <= apb_pkg::ACCESS;
        apb_pkg::ACCESS: if (done) state <= apb_pkg::IDLE;
        default:         state <= apb_pkg::IDLE;
      endcase
    end
  end

  // Held for the whole transfer
  always_ff @(posedge aclk) begin
    if (cmd_pop) begin
      cmd_q <= cmd_data;
    end
  end

  // Bus drive, select from the slave field
  assign psel    = (state != apb_pkg::IDLE) ? (sel_base << cmd_q.addr.fields.slave) : '0;
  assign penable = (state == apb_pkg::ACCESS);
  assign paddr   = cmd_q.addr.flat;
  assign pwdata  = cmd_q.wdata;
  assign pwrite  = cmd_q.write;

  // Ignore slaves we did not select
  assign pready_sel  = |(pready & psel);
  assign pslverr_sel = |(pslverr & psel);
  assign done        = penable && pready_sel;

  // ------------------------------
  // Response routing
  // ------------------------------
  assign wr_rsp_push  = done && cmd_q.write;
  assign rd_rsp_push  = done && !cmd_q.write;
  assign wr_rsp_error = pslverr_sel;
  assign rd_rsp_data  = '{data: prdata, error: pslverr_sel};

endmodule

`default_nettype wire

//--- verilog/axi_apb_bridge.sv
// ------------------------------
// AXI4-Lite to APB bridge top
// Single clock, sync active high reset
// Four APB slaves, one-hot psel
// WSTRB is not supported
// ------------------------------
`default_nettype none

`include "bridge_macros.svh"

module axi_apb_bridge (
  input  logic                          aclk,
  input  logic                          reset,
  // AXI4-Lite slave
  input  logic [`BRIDGE_ADDR_WIDTH-1:0] awaddr,
  input  logic                          awvalid,
  output logic                          awready,
  input  logic [`BRIDGE_DATA_WIDTH-1:0] wdata,
  input  logic                          wvalid,
  output logic                          wready,
  output logic [1:0]                    bresp,
  output logic                          bvalid,
  input  logic                          bready,
  input  logic [`BRIDGE_ADDR_WIDTH-1:0] araddr,
  input  logic                          arvalid,
  output logic                          arready,
  output logic [`BRIDGE_DATA_WIDTH-1:0] rdata,
  output logic [1:0]                    rresp,
  output logic                          rvalid,
  input  logic                          rready,
  // APB master
  output logic [`BRIDGE_ADDR_WIDTH-1:0] paddr,
  output logic [`BRIDGE_DATA_WIDTH-1:0] pwdata,
  output logic [`BRIDGE_NUM_SLAVES-1:0] psel,
  output logic                          penable,
  output logic                          pwrite,
  input  logic [`BRIDGE_DATA_WIDTH-1:0] prdata,
  input  logic [`BRIDGE_NUM_SLAVES-1:0] pready,
  input  logic [`BRIDGE_NUM_SLAVES-1:0] pslverr
);

  // Command path
  apb_pkg::apb_cmd_t cmd_push_data;
  apb_pkg::apb_cmd_t cmd_pop_data;
  logic              cmd_push;
  logic              cmd_pop;
  logic              cmd_full;
  logic              cmd_empty;

  // Write response path
  logic wr_rsp_push;
  logic wr_rsp_push_error;
  logic wr_rsp_full;
  logic wr_rsp_pop;
  logic wr_rsp_pop_error;
  logic wr_rsp_empty;

  // Read response path
  axi_pkg::rd_rsp_t rd_rsp_push_data;
  axi_pkg::rd_rsp_t rd_rsp_pop_data;
  logic             rd_rsp_push;
  logic             rd_rsp_full;
  logic             rd_rsp_pop;
  logic             rd_rsp_empty;

  axi_lite_front u_front (
    .aclk         (aclk),
    .reset        (reset),
    .awaddr       (awaddr),
    .awvalid      (awvalid),
    .awready      (awready),
    .wdata        (wdata),
    .wvalid       (wvalid),
    .wready       (wready),
    .bresp        (bresp),
    .bvalid       (bvalid),
    .bready       (bready),
    .araddr       (araddr),
    .arvalid      (arvalid),
    .arready      (arready),
    .rdata        (rdata),
    .rresp        (rresp),
    .rvalid       (rvalid),
    .rready       (rready),
    .cmd_push     (cmd_push),
    .cmd_data     (cmd_push_data),
    .cmd_full     (cmd_full),
    .wr_rsp_pop   (wr_rsp_pop),
    .wr_rsp_error (wr_rsp_pop_error),
    .wr_rsp_empty (wr_rsp_empty),
    .rd_rsp_pop   (rd_rsp_pop),
    .rd_rsp_data  (rd_rsp_pop_data),
    .rd_rsp_empty (rd_rsp_empty)
  );

  // ------------------------------
  // Buffers between the two sides
  // ------------------------------
  sync_fifo #(
    .width ($bits(apb_pkg::apb_cmd_t)),
    .depth (`BRIDGE_FIFO_DEPTH)
  ) u_cmd_fifo (
    .aclk      (aclk),
    .reset     (reset),
    .push      (cmd_push),
    .push_data (cmd_push_data),
    .full      (cmd_full),
    .pop       (cmd_pop),
    .pop_data  (cmd_pop_data),
    .empty     (cmd_empty)
  );

  // Only the error bit comes back for writes
  sync_fifo #(
    .width (1),
    .depth (`BRIDGE_FIFO_DEPTH)
  ) u_wr_rsp_fifo (
    .aclk      (aclk),
    .reset     (reset),
    .push      (wr_rsp_push),
    .push_data (wr_rsp_push_error),
    .full      (wr_rsp_full),
    .pop       (wr_rsp_pop),
    .pop_data  (wr_rsp_pop_error),
    .empty     (wr_rsp_empty)
  );

  sync_fifo #(
    .width ($bits(axi_pkg::rd_rsp_t)),
    .depth (`BRIDGE_FIFO_DEPTH)
  ) u_rd_rsp_fifo (
    .aclk      (aclk),
    .reset     (reset),
    .push      (rd_rsp_push),
    .push_data (rd_rsp_push_data),
    .full      (rd_rsp_full),
    .pop       (rd_rsp_pop),
    .pop_data  (rd_rsp_pop_data),
    .empty     (rd_rsp_empty)
  );

  apb_master u_master (
    .aclk         (aclk),
    .reset        (reset),
    .cmd_data     (cmd_pop_data),
    .cmd_empty    (cmd_empty),
    .cmd_pop      (cmd_pop),
    .wr_rsp_full  (wr_rsp_full),
    .wr_rsp_push  (wr_rsp_push),
    .wr_rsp_error (wr_rsp_push_error),
    .rd_rsp_full  (rd_rsp_full),
    .rd_rsp_push  (rd_rsp_push),
    .rd_rsp_data  (rd_rsp_push_data),
    .paddr        (paddr),
    .pwdata       (pwdata),
    .psel         (psel),
    .penable      (penable),
    .pwrite       (pwrite),
    .prdata       (prdata),
    .pready       (pready),
    .pslverr      (pslverr)
  );

endmodule

`default_nettype wire

//--- sim/tb_clock.sv
// ------------------------------
// Free running clock, period 4
// Starts low at time zero
// ------------------------------
`default_nettype none

module tb_clock (
  output logic aclk
);

  initial begin
    aclk = 1'b0;
    // Half period of 2
    forever #2 aclk = ~aclk;
  end

endmodule

`default_nettype wire

//--- sim/apb_slave_model.sv
// ------------------------------
// Four behavioral APB slaves on one bus
// 16 words each, word index from paddr bits 5:2
// Odd slaves add one wait state
// Offset bit 11 set gives PSLVERR and no store
// Unselected slaves hold PREADY and PSLVERR high
// ------------------------------
`default_nettype none

`include "bridge_macros.svh"

module apb_slave_model (
  input  logic                          aclk,
  input  logic                          reset,
  input  logic [`BRIDGE_ADDR_WIDTH-1:0] paddr,
  input  logic [`BRIDGE_DATA_WIDTH-1:0] pwdata,
  input  logic [`BRIDGE_NUM_SLAVES-1:0] psel,
  input  logic                          penable,
  input  logic                          pwrite,
  output logic [`BRIDGE_DATA_WIDTH-1:0] prdata,
  output logic [`BRIDGE_NUM_SLAVES-1:0] pready,
  output logic [`BRIDGE_NUM_SLAVES-1:0] pslverr
);

  logic [`BRIDGE_DATA_WIDTH-1:0] mem [`BRIDGE_NUM_SLAVES][16];
  // One flag per slave, set after the first ACCESS cycle
  logic [`BRIDGE_NUM_SLAVES-1:0] waited;
  logic [3:0]                    index;
  logic                          err;

  assign index = paddr[5:2];
  assign err   = paddr[11];

  // ------------------------------
  // Bus response
  // ------------------------------
  always_comb begin
    prdata = '0;
    for (int s = 0; s < `BRIDGE_NUM_SLAVES; s++) begin
      if (psel[s]) begin
        // Even slaves answer at once
        pready[s]  = ((s % 2) == 0) || waited[s];
        pslverr[s] = err;
        prdata     = mem[s][index];
      end else begin
        // Idle slaves park high on purpose
        pready[s]  = 1'b1;
        pslverr[s] = 1'b1;
      end
    end
  end

  // Storage and wait state tracking
  always_ff @(posedge aclk) begin
    if (reset) begin
      waited <= '0;
      for (int s = 0; s < `BRIDGE_NUM_SLAVES; s++) begin
        for (int w = 0; w < 16; w++) begin
          // Fill differs per slave and per word
          mem[s][w] <= 32'h5a00_0000 | (s << 8) | w;
        end
      end
    end else begin
      for (int s = 0; s < `BRIDGE_NUM_SLAVES; s++) begin
        if (psel[s] && penable) begin
          if (pready[s]) begin
            waited[s] <= 1'b0;
            if (pwrite && !err) begin
              mem[s][index] <= pwdata;
            end
          end else begin
            waited[s] <= 1'b1;
          end
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- sim/bridge_props.sv
// ------------------------------
// Protocol checks bound into the bridge top
// Disabled while reset is high
// ------------------------------
`default_nettype none

`include "bridge_macros.svh"

module bridge_props (
  input logic                          aclk,
  input logic                          reset,
  input logic [`BRIDGE_NUM_SLAVES-1:0] psel,
  input logic                          penable,
  input logic [`BRIDGE_ADDR_WIDTH-1:0] paddr,
  input logic                          bvalid,
  input logic                          bready,
  input logic                          rvalid,
  input logic                          rready
);

  // Bumped by every failing property below
  int assert_failures = 0;

  // ------------------------------
  // APB side
  // ------------------------------
  penable_has_psel: assert property (@(posedge aclk) disable iff (reset)
    penable |-> (psel != '0))
    else begin
      assert_failures++;
      $error("penable high with no slave selected");
    end

  psel_onehot: assert property (@(posedge aclk) disable iff (reset)
    $onehot0(psel))
    else begin
      assert_failures++;
      $error("more than one psel bit high");
    end

  // SETUP is psel without penable, ACCESS follows
  paddr_held: assert property (@(posedge aclk) disable iff (reset)
    ((psel != '0) && !penable) |=> $stable(paddr))
    else begin
      assert_failures++;
      $error("paddr changed between SETUP and ACCESS");
    end

  // ------------------------------
  // AXI response channels
  // ------------------------------
  bvalid_held: assert property (@(posedge aclk) disable iff (reset)
    (bvalid && !bready) |=> bvalid)
    else begin
      assert_failures++;
      $error("bvalid dropped before bready");
    end

  rvalid_held: assert property (@(posedge aclk) disable iff (reset)
    (rvalid && !rready) |=> rvalid)
    else begin
      assert_failures++;
      $error("rvalid dropped before rready");
    end

endmodule

bind axi_apb_bridge bridge_props u_props (
  .aclk    (aclk),
  .reset   (reset),
  .psel    (psel),
  .penable (penable),
  .paddr   (paddr),
  .bvalid  (bvalid),
  .bready  (bready),
  .rvalid  (rvalid),
  .rready  (rready)
);

`default_nettype wire

//--- sim/tb_axi_apb_bridge.sv
// ------------------------------
// Bridge testbench, one AXI transaction per table row
// Inputs change 1 unit after the rising edge
// Expected values follow the slave model rules
// Pair and back-pressure cases run after the table
// ------------------------------
`default_nettype none

`include "bridge_macros.svh"

module tb_axi_apb_bridge;

  // One write more than the write path can hold
  localparam int burst_len = 2 * `BRIDGE_FIFO_DEPTH + 1;

  logic                          aclk;
  logic                          reset;
  logic [`BRIDGE_ADDR_WIDTH-1:0] awaddr;
  logic                          awvalid;
  logic                          awready;
  logic [`BRIDGE_DATA_WIDTH-1:0] wdata;
  logic                          wvalid;
  logic                          wready;
  logic [1:0]                    bresp;
  logic                          bvalid;
  logic                          bready;
  logic [`BRIDGE_ADDR_WIDTH-1:0] araddr;
  logic                          arvalid;
  logic                          arready;
  logic [`BRIDGE_DATA_WIDTH-1:0] rdata;
  logic [1:0]                    rresp;
  logic                          rvalid;
  logic                          rready;
  logic [`BRIDGE_ADDR_WIDTH-1:0] paddr;
  logic [`BRIDGE_DATA_WIDTH-1:0] pwdata;
  logic [`BRIDGE_NUM_SLAVES-1:0] psel;
  logic                          penable;
  logic                          pwrite;
  logic [`BRIDGE_DATA_WIDTH-1:0] prdata;
  logic [`BRIDGE_NUM_SLAVES-1:0] pready;
  logic [`BRIDGE_NUM_SLAVES-1:0] pslverr;

  // Stimulus table, one entry per row in each queue
  logic        row_wr[$];
  logic [31:0] row_addr[$];
  logic [31:0] row_data[$];
  logic [1:0]  row_resp[$];
  logic [31:0] row_rdata[$];
  // Expected slave contents while the table is built
  logic [31:0] ref_mem [`BRIDGE_NUM_SLAVES][16];
  logic [31:0] burst_data [burst_len];

  // Bus as seen in the last ACCESS cycle
  logic [`BRIDGE_NUM_SLAVES-1:0] seen_psel;
  logic [`BRIDGE_ADDR_WIDTH-1:0] seen_paddr;

  integer seed;
  int     error_count;
  int     check_count;
  int     cycle_count;
  int     access_cycles;
  int     b_count;
  int     b_bad;

  tb_clock u_clock (
    .aclk (aclk)
  );

  axi_apb_bridge u_dut (
    .aclk    (aclk),
    .reset   (reset),
    .awaddr  (awaddr),
    .awvalid (awvalid),
    .awready (awready),
    .wdata   (wdata),
    .wvalid  (wvalid),
    .wready  (wready),
    .bresp   (bresp),
    .bvalid  (bvalid),
    .bready  (bready),
    .araddr  (araddr),
    .arvalid (arvalid),
    .arready (arready),
    .rdata   (rdata),
    .rresp   (rresp),
    .rvalid  (rvalid),
    .rready  (rready),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr)
  );

  apb_slave_model u_slaves (
    .aclk    (aclk),
    .reset   (reset),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr)
  );

  // ------------------------------
  // Monitors
  // ------------------------------
  // ACCESS cycles of the current transfer, with its select and address
  always @(posedge aclk) begin
    if (penable) begin
      access_cycles++;
      seen_psel  = psel;
      seen_paddr = paddr;
    end
  end

  // Every B handshake, and those not OKAY
  always @(posedge aclk) begin
    if (bvalid && bready) begin
      b_count++;
      if (bresp != axi_pkg::OKAY) begin
        b_bad++;
      end
    end
  end

  // ------------------------------
  // Helpers
  // ------------------------------
  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    check_count++;
    assert (got === exp) else begin
      error_count++;
      $display("[ERROR] t=%0t signal=%s got=%h expected=%h", $time, name, got, exp);
    end
  endtask

  // Expected response and read data from the model rules
  task automatic add_row(input logic wr, input logic [31:0] addr, input logic [31:0] data);
    logic [1:0] slave;
    logic       err;
    slave = addr[13:12];
    err   = addr[11];
    row_wr.push_back(wr);
    row_addr.push_back(addr);
    row_data.push_back(data);
    row_resp.push_back(err ? axi_pkg::SLVERR : axi_pkg::OKAY);
    row_rdata.push_back(ref_mem[slave][addr[5:2]]);
    if (wr && !err) begin
      ref_mem[slave][addr[5:2]] = data;
    end
  endtask

  // AW and W offered together
  task automatic send_write(input logic [31:0] addr, input logic [31:0] data);
    @(posedge aclk);
    #1;
    awaddr  = addr;
    wdata   = data;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    @(posedge aclk);
    while (!awready) @(posedge aclk);
    check_value("wready", wready, 1'b1);
    #1;
    awvalid = 1'b0;
    wvalid  = 1'b0;
  endtask

  task automatic send_read(input logic [31:0] addr);
    @(posedge aclk);
    #1;
    araddr  = addr;
    arvalid = 1'b1;
    @(posedge aclk);
    while (!arready) @(posedge aclk);
    #1;
    arvalid = 1'b0;
  endtask

  // bready is high here, so the sampled edge is the handshake
  task automatic wait_b(output logic [1:0] resp);
    @(posedge aclk);
    while (!bvalid) @(posedge aclk);
    resp = bresp;
    #1;
  endtask

  task automatic wait_r(output logic [1:0] resp, output logic [31:0] data);
    @(posedge aclk);
    while (!rvalid) @(posedge aclk);
    resp = rresp;
    data = rdata;
    #1;
  endtask

  // ------------------------------
  // Cycle limit
  // ------------------------------
  initial begin
    cycle_count = 0;
    while (cycle_count <= 100 * row_wr.size() + 2000) begin
      @(posedge aclk);
      cycle_count++;
    end
    $display("Timeout: the run went past %0d cycles without finishing", cycle_count - 1);
    $display("STATUS: FAIL");
    $finish;
  end

  // ------------------------------
  // Main sequence
  // ------------------------------
  initial begin
    logic [1:0]  resp;
    logic [31:0] data;
    logic [31:0] addr;
    int          b_start;
    int          bad_start;
    int          taken;
    seed          = 32'h03015ccb;
    error_count   = 0;
    check_count   = 0;
    access_cycles = 0;
    b_count       = 0;
    b_bad         = 0;
    reset   = 1'b1;
    awaddr  = '0;
    awvalid = 1'b0;
    wdata   = '0;
    wvalid  = 1'b0;
    bready  = 1'b1;
    araddr  = '0;
    arvalid = 1'b0;
    rready  = 1'b1;

    // Write and read back per slave, upper bits are not decoded
    for (int s = 0; s < `BRIDGE_NUM_SLAVES; s++) begin
      addr = 32'h4000_0000 | (s << 12) | (4 * s + 4);
      data = $random(seed);
      add_row(1'b1, addr, data);
      add_row(1'b0, addr, '0);
    end
    // Good write, rejected write, error read, then the kept word
    for (int s = 1; s <= 2; s++) begin
      addr = (s << 12) | 32'h020;
      data = $random(seed);
      add_row(1'b1, addr, data);
      data = $random(seed);
      add_row(1'b1, addr | 32'h800, data);
      add_row(1'b0, addr | 32'h800, '0);
      add_row(1'b0, addr, '0);
    end

    repeat (5) @(posedge aclk);
    #1;
    reset = 1'b0;

    for (int i = 0; i < row_wr.size(); i++) begin
      access_cycles = 0;
      seen_psel     = '0;
      if (row_wr[i]) begin
        send_write(row_addr[i], row_data[i]);
        wait_b(resp);
        check_value("bresp", resp, row_resp[i]);
      end else begin
        send_read(row_addr[i]);
        wait_r(resp, data);
        check_value("rresp", resp, row_resp[i]);
        // Error reads carry no data
        if (row_resp[i] == axi_pkg::OKAY) begin
          check_value("rdata", data, row_rdata[i]);
        end
      end
      // Odd slave index means one wait state
      check_value("access_cycles", access_cycles, row_addr[i][12] ? 2 : 1);
      // Slave field picks one of four selects
      check_value("psel", seen_psel, 4'b0001 << row_addr[i][13:12]);
      check_value("paddr", seen_paddr, row_addr[i]);
    end

    // Write and read in the same cycle, write goes first
    data = $random(seed);
    @(posedge aclk);
    #1;
    awaddr  = 32'h0000_1008;
    wdata   = data;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    araddr  = 32'h0000_1008;
    arvalid = 1'b1;
    @(posedge aclk);
    while (!awready) @(posedge aclk);
    check_value("arready", arready, 1'b0);
    #1;
    awvalid = 1'b0;
    wvalid  = 1'b0;
    @(posedge aclk);
    while (!arready) @(posedge aclk);
    #1;
    arvalid = 1'b0;
    wait_b(resp);
    check_value("bresp", resp, axi_pkg::OKAY);
    wait_r(resp, addr);
    check_value("rresp", resp, axi_pkg::OKAY);
    check_value("rdata", addr, data);

    // Back-pressure on B until the write path is full
    bready    = 1'b0;
    b_start   = b_count;
    bad_start = b_bad;
    for (int k = 0; k < burst_len - 1; k++) begin
      burst_data[k] = $random(seed);
      send_write(4 * k, burst_data[k]);
    end
    burst_data[burst_len-1] = $random(seed);
    @(posedge aclk);
    #1;
    awaddr  = 4 * (burst_len - 1);
    wdata   = burst_data[burst_len-1];
    awvalid = 1'b1;
    wvalid  = 1'b1;
    taken   = 0;
    repeat (40) begin
      @(posedge aclk);
      if (awready) begin
        taken++;
      end
    end
    check_value("awready", taken, 0);
    #1;
    bready = 1'b1;
    @(posedge aclk);
    while (!awready) @(posedge aclk);
    #1;
    awvalid = 1'b0;
    wvalid  = 1'b0;
    while (b_count - b_start < burst_len) begin
      @(posedge aclk);
      #1;
    end
    check_value("bresp", b_bad - bad_start, 0);
    // Every held write must have landed in slave 0
    for (int k = 0; k < burst_len; k++) begin
      send_read(4 * k);
      wait_r(resp, data);
      check_value("rresp", resp, axi_pkg::OKAY);
      check_value("rdata", data, burst_data[k]);
    end

    // Protocol property failures count as errors too
    error_count += u_dut.u_props.assert_failures;
    $display("Checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- sim.f
+incdir+include
verilog/axi_pkg.sv
verilog/apb_pkg.sv
verilog/sync_fifo.sv
verilog/axi_lite_front.sv
verilog/apb_master.sv
verilog/axi_apb_bridge.sv
sim/tb_clock.sv
sim/apb_slave_model.sv
sim/bridge_props.sv
sim/tb_axi_apb_bridge.sv
